// ==== source/ts_pkg.sv ====
package ts_pkg;

	// Transport stream constants
	localparam logic [7:0] TS_SYNC_BYTE = 8'h47;
	localparam logic [7:0] TS_PKT_BYTES = 8'd188;
	localparam logic [5:0] TS_PKT_WORDS = 6'd47;

	// Register map, byte addresses
	localparam logic [8:0] REG_CTRL   = 9'h000;
	localparam logic [8:0] REG_PID    = 9'h004;
	localparam logic [8:0] REG_COUNT  = 9'h008;
	localparam logic [8:0] REG_STATUS = 9'h00C;
	localparam logic [8:0] BUF_BASE   = 9'h100;
	localparam logic [8:0] BUF_END    = 9'h1BB; // Last byte of word 46

	// One stream byte
	typedef struct packed {
		logic       valid;
		logic       sync;
		logic [7:0] data;
	} ts_byte_t;

	// Packed word from filter to buffer
	typedef struct packed {
		logic        valid;
		logic [5:0]  idx;
		logic [31:0] data;
		logic        last;
	} ts_word_t;

	// PID register fields, pid in the low bits
	typedef struct packed {
		logic [14:0] rsvd_hi;
		logic        pid_en;
		logic [2:0]  rsvd_lo;
		logic [12:0] pid;
	} pid_fields_t;

	typedef union packed {
		logic [31:0] raw;
		pid_fields_t f;
	} pid_reg_u;

	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [8:0]  adr;
		logic [31:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic        ack;
		logic [31:0] dat;
	} wb_rsp_t;

endpackage

// ==== source/ts_regs.sv ====
`timescale 1ns/10ps

module ts_regs (
	input  logic             clk,
	input  logic             rst_n,
	input  ts_pkg::wb_req_t  wb_req,
	output ts_pkg::wb_rsp_t  wb_rsp,
	input  logic [31:0]      match_count,
	input  logic [31:0]      rd_data,
	input  logic             done,
	input  logic             armed,
	output logic             match_enable,
	output ts_pkg::pid_reg_u cfg_pid,
	output logic             arm,
	output logic [5:0]       rd_word
);
	import ts_pkg::*;

	logic        ack_q;
	logic        req_hit;
	logic        wr_hit;
	logic        in_buf;
	logic        buf_sel_q;
	logic [31:0] reg_rdata;
	logic [31:0] reg_rdata_q;
	pid_reg_u    pid_wr;
	pid_reg_u    pid_keep;

	// New request only while ack is low
	assign req_hit = wb_req.cyc && wb_req.stb && !ack_q;
	assign wr_hit  = req_hit && wb_req.we;

	assign in_buf  = (wb_req.adr >= BUF_BASE) && (wb_req.adr <= BUF_END);
	assign rd_word = in_buf ? wb_req.adr[7:2] : '0; // Buffer reads one cycle ahead of ack

	// Keep pid and enable, reserved bits read back zero
	always_comb begin
		pid_wr.raw          = wb_req.dat;
		pid_keep.raw        = '0;
		pid_keep.f.pid      = pid_wr.f.pid;
		pid_keep.f.pid_en   = pid_wr.f.pid_en;
	end

	always_comb begin
		case (wb_req.adr)
			REG_CTRL:   reg_rdata = {31'd0, match_enable}; // Arm reads zero
			REG_PID:    reg_rdata = cfg_pid.raw;
			REG_COUNT:  reg_rdata = match_count;
			REG_STATUS: reg_rdata = {30'd0, armed, done};
			default:    reg_rdata = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ack_q        <= 1'b0;
			arm          <= 1'b0;
			buf_sel_q    <= 1'b0;
			match_enable <= 1'b0;
			cfg_pid      <= '0;
		end else begin
			ack_q <= req_hit;
			arm   <= wr_hit && (wb_req.adr == REG_CTRL) && wb_req.dat[1];
			if (req_hit) begin
				buf_sel_q <= in_buf;
			end
			if (wr_hit && (wb_req.adr == REG_CTRL)) begin
				match_enable <= wb_req.dat[0];
			end
			if (wr_hit && (wb_req.adr == REG_PID)) begin
				cfg_pid <= pid_keep;
			end
		end
	end

	// Register view sampled with the request
	always_ff @(posedge clk) begin
		if (req_hit) begin
			reg_rdata_q <= reg_rdata;
		end
	end

	assign wb_rsp.ack = ack_q;
	assign wb_rsp.dat = buf_sel_q ? rd_data : reg_rdata_q;

endmodule

// ==== source/ts_pid_filter.sv ====
`timescale 1ns/10ps

module ts_pid_filter (
	input  logic             clk,
	input  logic             rst_n,
	input  ts_pkg::ts_byte_t ts_in,
	input  logic             match_enable,
	input  ts_pkg::pid_reg_u cfg_pid,
	output ts_pkg::ts_word_t word_out,
	output logic [31:0]      match_count
);
	import ts_pkg::*;

	logic [7:0]  pos;       // Index of the next byte, TS_PKT_BYTES when idle
	logic [7:0]  cur;
	logic        pkt_start;
	logic        take;
	logic        matched;
	logic        pid_hit;
	logic [23:0] acc;       // Low three bytes of the word being built
	logic        wo_valid;
	logic [5:0]  wo_idx;
	logic [31:0] wo_data;
	logic        wo_last;

	assign pkt_start = ts_in.valid && ts_in.sync && (ts_in.data == TS_SYNC_BYTE);
	assign cur       = pkt_start ? 8'd0 : pos;
	assign take      = ts_in.valid && (cur < TS_PKT_BYTES);

	// PID is byte 1 low bits followed by byte 2
	assign pid_hit = ({acc[12:8], ts_in.data} == cfg_pid.f.pid) &&
		cfg_pid.f.pid_en && match_enable;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pos         <= TS_PKT_BYTES;
			matched     <= 1'b0;
			match_count <= '0;
			wo_valid    <= 1'b0;
		end else begin
			wo_valid <= take && matched && (cur[1:0] == 2'd3);
			if (take) begin
				pos <= cur + 8'd1;
				if (cur == 8'd0) begin
					matched <= 1'b0;
				end else if (cur == 8'd2) begin
					matched <= pid_hit;
					if (pid_hit) begin
						match_count <= match_count + 32'd1;
					end
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			case (cur[1:0])
				2'd0:    acc[7:0]   <= ts_in.data;
				2'd1:    acc[15:8]  <= ts_in.data;
				2'd2:    acc[23:16] <= ts_in.data;
				default: acc        <= acc; // Byte 3 goes straight into the word
			endcase
			wo_idx  <= cur[7:2];
			wo_data <= {ts_in.data, acc};
			wo_last <= (cur[7:2] == TS_PKT_WORDS - 6'd1);
		end
	end

	assign word_out.valid = wo_valid;
	assign word_out.idx   = wo_idx;
	assign word_out.data  = wo_data;
	assign word_out.last  = wo_last;

endmodule

// ==== source/ts_capture_buf.sv ====
`timescale 1ns/10ps

module ts_capture_buf (
	input  logic             clk,
	input  logic             rst_n,
	input  ts_pkg::ts_word_t word_in,
	input  logic             arm,
	input  logic [5:0]       rd_word,
	output logic [31:0]      rd_data,
	output logic             done,
	output logic             armed
);
	import ts_pkg::*;

	logic [31:0] mem [0:TS_PKT_WORDS-1];
	logic        capturing;
	logic        first_word;
	logic        wr_en;

	assign first_word = word_in.valid && (word_in.idx == 6'd0);

	// Mid-packet words after arm belong to a packet already in flight
	assign wr_en = word_in.valid && armed && !arm && (capturing || first_word);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			armed     <= 1'b0;
			done      <= 1'b0;
			capturing <= 1'b0;
		end else if (arm) begin
			armed     <= 1'b1;
			done      <= 1'b0;
			capturing <= 1'b0;
		end else if (wr_en) begin
			if (word_in.last) begin
				armed     <= 1'b0;
				capturing <= 1'b0;
				done      <= 1'b1;
			end else begin
				capturing <= 1'b1; // Word 0 also restarts a partial capture
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[word_in.idx] <= word_in.data;
		end
	end

	// Registered read, lines up with the bus ack
	always_ff @(posedge clk) begin
		if (rd_word < TS_PKT_WORDS) begin
			rd_data <= mem[rd_word];
		end else begin
			rd_data <= '0;
		end
	end

endmodule

// ==== source/ts_monitor.sv ====
`timescale 1ns/10ps

module ts_monitor (
	input  logic             clk,
	input  logic             rst_n,
	input  ts_pkg::wb_req_t  wb_req,
	output ts_pkg::wb_rsp_t  wb_rsp,
	input  ts_pkg::ts_byte_t ts_in
);
	import ts_pkg::*;

	logic        match_enable;
	pid_reg_u    cfg_pid;
	logic        arm;
	logic [5:0]  rd_word;
	logic [31:0] rd_data;
	logic        done;
	logic        armed;
	logic [31:0] match_count;
	ts_word_t    pkt_word;

	ts_regs u_regs (
		.clk          (clk),
		.rst_n        (rst_n),
		.wb_req       (wb_req),
		.wb_rsp       (wb_rsp),
		.match_count  (match_count),
		.rd_data      (rd_data),
		.done         (done),
		.armed        (armed),
		.match_enable (match_enable),
		.cfg_pid      (cfg_pid),
		.arm          (arm),
		.rd_word      (rd_word)
	);

	ts_pid_filter u_filter (
		.clk          (clk),
		.rst_n        (rst_n),
		.ts_in        (ts_in),
		.match_enable (match_enable),
		.cfg_pid      (cfg_pid),
		.word_out     (pkt_word),
		.match_count  (match_count)
	);

	ts_capture_buf u_buf (
		.clk     (clk),
		.rst_n   (rst_n),
		.word_in (pkt_word),
		.arm     (arm),
		.rd_word (rd_word),
		.rd_data (rd_data),
		.done    (done),
		.armed   (armed)
	);

endmodule

// ==== test/ts_monitor_chk.sv ====
`timescale 1ns/10ps

module ts_monitor_chk (
	input logic            clk,
	input logic            rst_n,
	input ts_pkg::wb_req_t wb_req,
	input ts_pkg::wb_rsp_t wb_rsp,
	input logic            done,
	input logic            armed
);
	int assert_errors = 0;

	ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		wb_rsp.ack |=> !wb_rsp.ack)
		else begin
			$error("ack held high for more than one cycle");
			assert_errors++;
		end

	// Ack only answers a request
	ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
		wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb))
		else begin
			$error("ack without a preceding cyc and stb");
			assert_errors++;
		end

	done_xor_armed: assert property (@(posedge clk) disable iff (!rst_n)
		!(done && armed))
		else begin
			$error("done and armed set together");
			assert_errors++;
		end

	reset_state: assert property (@(posedge clk)
		!rst_n |=> (!wb_rsp.ack && !done && !armed))
		else begin
			$error("ack, done or armed high after reset");
			assert_errors++;
		end

endmodule

// ==== test/ts_scoreboard.sv ====
`timescale 1ns/10ps

module ts_scoreboard (
	input  logic             clk,
	input  logic             rst_n,
	input  ts_pkg::wb_req_t  wb_req,
	input  ts_pkg::wb_rsp_t  wb_rsp,
	input  ts_pkg::ts_byte_t ts_in,
	input  logic [95:0]      test_name,
	output int               err_count
);
	import ts_pkg::*;

	logic        m_en;
	logic [31:0] m_pid;
	logic [31:0] m_count;
	logic        m_done;
	logic        m_armed;
	logic        cap_on;     // Armed, no full packet captured yet
	logic        arm_pend;
	logic        done_pend;
	logic        pkt_cap;
	logic        pkt_hit;
	logic        req_new;
	logic        rd_pend;
	logic [8:0]  rd_adr;
	logic [31:0] exp_rd;
	logic [7:0]  pkt_bytes [0:187];
	logic [31:0] exp_mem [0:46];
	int          pos;
	int          ack_wait;

	function automatic logic [31:0] expect_read(input logic [8:0] adr);
		if (adr >= BUF_BASE && adr <= BUF_END) begin
			return exp_mem[adr[7:2]];
		end
		case (adr)
			REG_CTRL:   return {31'd0, m_en};
			REG_PID:    return m_pid;
			REG_COUNT:  return m_count;
			REG_STATUS: return {30'd0, m_armed, m_done};
			default:    return '0;
		endcase
	endfunction

	// Four bytes to a word, low byte first
	task automatic store_packet();
		for (int i = 0; i < 188; i++) begin
			exp_mem[i / 4][8 * (i % 4) +: 8] = pkt_bytes[i];
		end
	endtask

	always @(posedge clk) begin
		if (!rst_n) begin
			m_en = 1'b0;
			m_pid = '0;
			m_count = '0;
			m_done = 1'b0;
			m_armed = 1'b0;
			cap_on = 1'b0;
			arm_pend = 1'b0;
			done_pend = 1'b0;
			pkt_cap = 1'b0;
			pkt_hit = 1'b0;
			rd_pend = 1'b0;
			pos = TS_PKT_BYTES;
			ack_wait = 0;
			err_count = 0;
		end else begin
			if (wb_rsp.ack) begin
				if (rd_pend && wb_rsp.dat !== exp_rd) begin
					$display("MISMATCH %0s: address %h expected %h actual %h",
						test_name, rd_adr, exp_rd, wb_rsp.dat);
					err_count++;
				end
				rd_pend = 1'b0;
				ack_wait = 0;
			end else if (wb_req.cyc && wb_req.stb) begin
				if (ack_wait == 2) begin
					$display("Error in %0s: no ack within 2 cycles of the request to address %h",
						test_name, wb_req.adr);
					err_count++;
				end
				ack_wait++;
			end

			// Read data is sampled before this edge's updates
			req_new = wb_req.cyc && wb_req.stb && !wb_rsp.ack;
			if (req_new && !wb_req.we) begin
				exp_rd = expect_read(wb_req.adr);
				rd_adr = wb_req.adr;
				rd_pend = 1'b1;
			end

			if (done_pend) begin
				m_done = 1'b1;
				m_armed = 1'b0;
				done_pend = 1'b0;
			end
			if (arm_pend) begin
				m_armed = 1'b1;
				m_done = 1'b0;
				arm_pend = 1'b0;
			end

			if (ts_in.valid) begin
				if (ts_in.sync && ts_in.data == TS_SYNC_BYTE) begin
					pos = 0;
				end
				if (pos < TS_PKT_BYTES) begin
					pkt_bytes[pos] = ts_in.data;
					if (pos == 0) begin
						pkt_cap = cap_on;
						pkt_hit = 1'b0;
					end else if (pos == 2) begin
						pkt_hit = m_en && m_pid[16] &&
							({pkt_bytes[1][4:0], ts_in.data} == m_pid[12:0]);
						if (pkt_hit) begin
							m_count++;
						end
					end else if (pos == 187 && pkt_hit && pkt_cap && cap_on) begin
						store_packet();
						cap_on = 1'b0;
						done_pend = 1'b1; // Status follows one edge later
					end
					pos++;
				end
			end

			if (req_new && wb_req.we) begin
				if (wb_req.adr == REG_CTRL) begin
					m_en = wb_req.dat[0];
					if (wb_req.dat[1]) begin
						arm_pend = 1'b1;
						cap_on = 1'b1;
					end
				end else if (wb_req.adr == REG_PID) begin
					m_pid = wb_req.dat & 32'h0001_1fff; // pid and pid enable only
				end
			end
		end
	end

endmodule

// ==== test/tb_ts_monitor.sv ====
`timescale 1ns/10ps

module tb_ts_monitor;
	import ts_pkg::*;

	localparam int CYCLE_LIMIT = 60000;

	logic        clk;
	logic        rst_n;
	wb_req_t     wb_req;
	wb_rsp_t     wb_rsp;
	ts_byte_t    ts_in;
	logic [95:0] test_name;
	logic [12:0] prog_pid;
	logic [31:0] rdata;
	int          check_errors;
	int          timeouts = 0;
	int          cycles = 0;

	ts_monitor u_ts_monitor (
		.clk    (clk),
		.rst_n  (rst_n),
		.wb_req (wb_req),
		.wb_rsp (wb_rsp),
		.ts_in  (ts_in)
	);

	ts_scoreboard u_scoreboard (
		.clk       (clk),
		.rst_n     (rst_n),
		.wb_req    (wb_req),
		.wb_rsp    (wb_rsp),
		.ts_in     (ts_in),
		.test_name (test_name),
		.err_count (check_errors)
	);

	bind ts_monitor ts_monitor_chk u_chk (
		.clk    (clk),
		.rst_n  (rst_n),
		.wb_req (wb_req),
		.wb_rsp (wb_rsp),
		.done   (done),
		.armed  (armed)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: test did not finish within %0d cycles", CYCLE_LIMIT);
			timeouts++;
			$display("Errors: %0d check, %0d assertion, %0d timeout", check_errors,
				u_ts_monitor.u_chk.assert_errors, timeouts);
			$display("Regression failed");
			$finish;
		end
	end

	task automatic wb_write(input logic [8:0] adr, input logic [31:0] dat);
		@(posedge clk);
		wb_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat};
		@(posedge clk);
		while (!wb_rsp.ack) @(posedge clk);
		wb_req <= '0;
	endtask

	task automatic wb_read(input logic [8:0] adr, output logic [31:0] dat);
		@(posedge clk);
		wb_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: 32'd0};
		@(posedge clk);
		while (!wb_rsp.ack) @(posedge clk);
		dat = wb_rsp.dat;
		wb_req <= '0;
	endtask

	// Random idle cycles before each valid byte
	task automatic put_byte(input logic sync, input logic [7:0] data);
		while ($urandom_range(3) == 0) begin
			@(posedge clk);
			ts_in <= '{valid: 1'b0, sync: 1'($urandom), data: 8'($urandom)};
		end
		@(posedge clk);
		ts_in <= '{valid: 1'b1, sync: sync, data: data};
	endtask

	task automatic send_packet(input logic [12:0] pid, input int len);
		logic [7:0] d;
		int         r;
		put_byte(1'b1, TS_SYNC_BYTE);
		for (int i = 1; i < len; i++) begin
			r = $urandom_range(15);
			d = 8'($urandom);
			if (i == 1) begin
				d = {d[7:5], pid[12:8]};
			end else if (i == 2) begin
				d = pid[7:0];
			end
			if (i > 2 && r == 0) begin
				put_byte(1'b0, TS_SYNC_BYTE); // 0x47 in payload
			end else if (i > 2 && r == 1) begin
				put_byte(1'b1, (d == TS_SYNC_BYTE) ? 8'h00 : d);
			end else begin
				put_byte(1'b0, d);
			end
		end
	endtask

	// Last packet is always whole so nothing is in flight afterwards
	task automatic send_stream(input int n, input bit last_match);
		logic [12:0] pid;
		int          len;
		for (int k = 0; k < n; k++) begin
			pid = $urandom_range(1) ? prog_pid : 13'($urandom);
			len = ($urandom_range(7) == 0) ? $urandom_range(187, 3) : 188;
			if (k == n - 1) begin
				len = 188;
				pid = last_match ? prog_pid : pid;
			end
			send_packet(pid, len);
		end
		@(posedge clk);
		ts_in <= '0;
	endtask

	task automatic wait_done_and_read();
		rdata = '0;
		while (!rdata[0]) wb_read(REG_STATUS, rdata);
		for (int w = 0; w < TS_PKT_WORDS; w++) begin
			wb_read(BUF_BASE + 9'(4 * w), rdata);
		end
		wb_read(REG_COUNT, rdata);
	endtask

	initial begin
		void'($urandom(32'h2ccdf2b3));
		rst_n = 1'b0;
		wb_req = '0;
		ts_in = '0;
		prog_pid = '0;
		test_name = "reset";
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;

		wb_read(REG_CTRL, rdata);
		wb_read(REG_PID, rdata);
		wb_read(REG_COUNT, rdata);
		wb_read(REG_STATUS, rdata);
		wb_read(9'h010, rdata); // Unmapped

		test_name <= "register";
		repeat (6) begin
			wb_write(REG_PID, $urandom);
			wb_read(REG_PID, rdata);
			wb_write(REG_CTRL, 32'($urandom_range(1)));
			wb_read(REG_CTRL, rdata);
		end
		prog_pid = 13'($urandom);
		wb_write(REG_PID, {15'd0, 1'b1, 3'd0, prog_pid});
		wb_write(REG_CTRL, 32'h1);

		test_name <= "count";
		repeat (4) begin
			send_stream(10, 1'b0);
			wb_read(REG_COUNT, rdata);
		end

		test_name <= "capture";
		repeat (3) begin
			prog_pid = 13'($urandom);
			wb_write(REG_PID, {15'd0, 1'b1, 3'd0, prog_pid});
			wb_write(REG_CTRL, 32'h3);
			wb_read(REG_STATUS, rdata);
			wb_read(REG_CTRL, rdata); // Arm bit reads zero
			send_stream(1 + $urandom_range(2), 1'b1);
			wait_done_and_read();
		end

		test_name <= "enable_off";
		wb_write(REG_CTRL, 32'h2); // Arm with match enable off
		send_stream(4, 1'b1);
		wb_read(REG_COUNT, rdata);
		wb_read(REG_STATUS, rdata);
		wb_write(REG_CTRL, 32'h1);
		wb_write(REG_PID, {15'd0, 1'b0, 3'd0, prog_pid});
		send_stream(3, 1'b1);
		wb_read(REG_COUNT, rdata);
		wb_read(REG_STATUS, rdata);
		wb_write(REG_PID, {15'd0, 1'b1, 3'd0, prog_pid});
		send_stream(2, 1'b1);
		wait_done_and_read();

		repeat (2) @(posedge clk);
		$display("Errors: %0d check, %0d assertion, %0d timeout", check_errors,
			u_ts_monitor.u_chk.assert_errors, timeouts);
		if (check_errors == 0 && u_ts_monitor.u_chk.assert_errors == 0 && timeouts == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// ==== ts_monitor.f ====
source/ts_pkg.sv
source/ts_regs.sv
source/ts_pid_filter.sv
source/ts_capture_buf.sv
source/ts_monitor.sv
test/ts_monitor_chk.sv
test/ts_scoreboard.sv
test/tb_ts_monitor.sv

// ==== Bender.yml ====
package:
  name: ts_monitor

sources:
  - files:
      - source/ts_pkg.sv
      - source/ts_regs.sv
      - source/ts_pid_filter.sv
      - source/ts_capture_buf.sv
      - source/ts_monitor.sv
  - target: test
    files:
      - test/ts_monitor_chk.sv
      - test/ts_scoreboard.sv
      - test/tb_ts_monitor.sv
